// File: verilog/soc_io_config.svh
// io parameters; FIFO pointers assume a power-of-two depth, and the tap must lie inside clkdiv
`ifndef SOC_IO_CONFIG_SVH
`define SOC_IO_CONFIG_SVH

// keyboard byte queue
`define IO_FIFO_DEPTH 8
// pointer width, log2 of depth
`define IO_FIFO_AW 3

// start, 8 data lsb first, odd parity, stop
`define PS2_FRAME_BITS 11

// digits on the serial display board
`define SEG_DIGITS 8

// free-running divider width
`define CLKDIV_BITS 8
// divider bit whose rising edge is one shifter tick
// bit 2 gives one tick per 8 clocks
`define SEG_DIV_TAP 2

`endif

// File: verilog/soc_io_pkg.sv
// shared io types; segment patterns are active low with bit 7 as the decimal point
package soc_io_pkg;

    // one ps/2 scan byte
    typedef logic [7:0] kb_byte_t;

    // one hex digit of the display word
    typedef logic [3:0] nibble_t;

    // dp, g, f, e, d, c, b, a from msb down
    typedef logic [7:0] seg_pat_t;

    // eight hex digits
    typedef logic [31:0] seg_word_t;

    // keyboard frame receiver
    typedef enum logic [1:0] {idle, shift, check} ps2_state_t;

    // serial display shifter
    typedef enum logic [1:0] {
        wait_frame,
        bit_low,
        bit_high
    } shift_state_t;

endpackage

// File: verilog/seg_hex_encoder.sv
// combinational hex font; output is active low and the decimal point is always dark
`timescale 1ns/1ps

module seg_hex_encoder (
    input  soc_io_pkg::nibble_t  digit,
    output soc_io_pkg::seg_pat_t pattern
);
    import soc_io_pkg::*;

    // lit segments, one means on, bit 7 dp never lit
    seg_pat_t lit;

    always_comb begin
        case (digit)
            4'h0: lit = 8'h3f;
            4'h1: lit = 8'h06;
            4'h2: lit = 8'h5b;
            4'h3: lit = 8'h4f;
            4'h4: lit = 8'h66;
            4'h5: lit = 8'h6d;
            4'h6: lit = 8'h7d;
            4'h7: lit = 8'h07;
            4'h8: lit = 8'h7f;
            4'h9: lit = 8'h6f;
            // letters A b C d E F
            4'ha: lit = 8'h77;
            4'hb: lit = 8'h7c;
            4'hc: lit = 8'h39;
            4'hd: lit = 8'h5e;
            4'he: lit = 8'h79;
            default: lit = 8'h71;
        endcase
    end

    // board drives segments low to light
    assign pattern = ~lit;

endmodule

// File: verilog/ps2_kbd.sv
// PS/2 receiver; no frame timeout, so a broken frame only realigns after later clock edges
`timescale 1ns/1ps
`include "soc_io_config.svh"

module ps2_kbd (
    input  logic                 clk200m,
    input  logic                 rst,
    input  logic                 ps2_clk,
    input  logic                 ps2_data,
    input  logic                 rdn,
    output soc_io_pkg::kb_byte_t data,
    output logic                 ready,
    output logic                 overflow
);
    import soc_io_pkg::*;

    // two-flop synchronizers, idle lines are high
    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       fall;

    // frame receiver
    ps2_state_t                 state;
    logic [`PS2_FRAME_BITS-1:0] frame;
    logic [3:0]                 bit_cnt;
    logic                       frame_ok;

    // byte queue
    kb_byte_t               mem [`IO_FIFO_DEPTH];
    logic [`IO_FIFO_AW-1:0] wr_ptr;
    logic [`IO_FIFO_AW-1:0] rd_ptr;
    logic [`IO_FIFO_AW:0]   count;
    logic                   full;
    logic                   push;
    logic                   pop;
    logic                   drop;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // one-cycle pulse per synchronized falling edge
    assign fall = clk_prev & ~clk_sync[1];

    // bits arrive lsb first, so shift in from the top
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state   <= idle;
            frame   <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (fall) begin
                        frame   <= {data_sync[1], frame[`PS2_FRAME_BITS-1:1]};
                        bit_cnt <= 4'd1;
                        state   <= shift;
                    end
                end
                shift: begin
                    if (fall) begin
                        frame   <= {data_sync[1], frame[`PS2_FRAME_BITS-1:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        // stop bit just taken
                        if (bit_cnt == 4'(`PS2_FRAME_BITS - 1)) begin
                            state <= check;
                        end
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = ~frame[0] & frame[`PS2_FRAME_BITS-1] & (^frame[9:1]);

    assign full = (count == `IO_FIFO_DEPTH);
    assign pop  = ~rdn & (count != '0);
    // a pop in the same cycle frees the slot
    assign push = (state == check) & frame_ok & (~full | pop);
    assign drop = (state == check) & frame_ok & full & ~pop;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until the next read
            if (drop) begin
                overflow <= 1'b1;
            end else if (pop) begin
                overflow <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk200m) begin
        if (push) begin
            mem[wr_ptr] <= frame[8:1];
        end
    end

    assign data  = mem[rd_ptr];
    assign ready = (count != '0);

    a_count_bound: assert property (@(posedge clk200m) disable iff (rst)
        count <= `IO_FIFO_DEPTH);

    a_ovf_when_full: assert property (@(posedge clk200m) disable iff (rst)
        $rose(overflow) |-> $past(full));

endmodule

// File: verilog/seg_shifter.sv
// serial display driver; num changes land only at the next frame start, one tick per tap rise
`timescale 1ns/1ps
`include "soc_io_config.svh"

module seg_shifter (
    input  logic                                   clk200m,
    input  logic                                   rst,
    input  logic [`CLKDIV_BITS-1:0]                clkdiv,
    input  soc_io_pkg::seg_pat_t [`SEG_DIGITS-1:0] patterns,
    output logic                                   s_clk,
    output logic                                   s_clrn,
    output logic                                   sout,
    output logic                                   en
);
    import soc_io_pkg::*;

    logic                      tap_prev;
    logic                      tick;
    shift_state_t              state;
    logic [5:0]                bit_cnt;
    // digit 7 sits in the top byte
    logic [`SEG_DIGITS*8-1:0]  shreg;

    // rising transition of the divider tap
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            tap_prev <= 1'b0;
        end else begin
            tap_prev <= clkdiv[`SEG_DIV_TAP];
        end
    end

    assign tick = clkdiv[`SEG_DIV_TAP] & ~tap_prev;

    // board clear released one clock after reset
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            s_clrn <= 1'b0;
        end else begin
            s_clrn <= 1'b1;
        end
    end

    // two ticks per bit: data with clock low, then clock high
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state   <= wait_frame;
            bit_cnt <= '0;
            shreg   <= '0;
            s_clk   <= 1'b0;
            en      <= 1'b0;
        end else if (tick) begin
            case (state)
                wait_frame: begin
                    // snapshot all digits for the whole frame
                    shreg   <= patterns;
                    bit_cnt <= '0;
                    en      <= 1'b1;
                    state   <= bit_low;
                end
                bit_low: begin
                    s_clk <= 1'b1;
                    state <= bit_high;
                end
                default: begin
                    s_clk <= 1'b0;
                    if (bit_cnt == 6'(`SEG_DIGITS * 8 - 1)) begin
                        // one tick gap with en low
                        en    <= 1'b0;
                        state <= wait_frame;
                    end else begin
                        shreg   <= {shreg[`SEG_DIGITS*8-2:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= bit_low;
                    end
                end
            endcase
        end
    end

    // data trails each tick by one clock, so it never moves together with s_clk
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            sout <= 1'b0;
        end else begin
            sout <= shreg[`SEG_DIGITS*8-1];
        end
    end

    // data must be stable around every clock edge on the board
    a_clk_data_apart: assert property (@(posedge clk200m) disable iff (rst)
        !($changed(s_clk) && $changed(sout)));

endmodule

// File: verilog/io_top.sv
// io side of the soc; clk200m comes in single-ended, the processor is outside via rdn and num
`timescale 1ns/1ps
`include "soc_io_config.svh"

module io_top (
    input  logic                  clk200m,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    input  logic                  rdn,
    input  soc_io_pkg::seg_word_t num,
    output soc_io_pkg::kb_byte_t  kb_rdata,
    output logic                  kb_ready,
    output logic                  overflow,
    output logic                  seg_clk,
    output logic                  seg_clrn,
    output logic                  seg_dt,
    output logic                  seg_en
);
    import soc_io_pkg::*;

    // free-running divider, taps pace slow logic
    logic [`CLKDIV_BITS-1:0] clkdiv;

    // one pattern per digit, digit 7 highest
    seg_pat_t [`SEG_DIGITS-1:0] seg_pats;

    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clkdiv <= '0;
        end else begin
            clkdiv <= clkdiv + 1'b1;
        end
    end

    // keyboard runs at full clock rate
    ps2_kbd u_ps2_kbd (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .rdn      (rdn),
        .data     (kb_rdata),
        .ready    (kb_ready),
        .overflow (overflow)
    );

    // nibble g of num drives digit g
    for (genvar g = 0; g < `SEG_DIGITS; g++) begin : gen_enc
        seg_hex_encoder u_enc (
            .digit   (num[4*g +: 4]),
            .pattern (seg_pats[g])
        );
    end

    seg_shifter u_seg_shifter (
        .clk200m  (clk200m),
        .rst      (rst),
        .clkdiv   (clkdiv),
        .patterns (seg_pats),
        .s_clk    (seg_clk),
        .s_clrn   (seg_clrn),
        .sout     (seg_dt),
        .en       (seg_en)
    );

endmodule

// File: testbench/tb_io_top.sv
// reads testbench/io_stimulus.txt relative to the run directory, so run from the project root
`timescale 1ns/1ps

module tb_io_top;

    // ps/2 half period in clk200m cycles, 160 ns
    localparam int half_ps2 = 20;
    // one display frame, 128 bit ticks plus the gap tick, 8 cycles per tick
    localparam int disp_cycles = 129 * 8;

    logic        clk200m = 1'b0;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic        rdn;
    logic [31:0] num;
    logic [7:0]  kb_rdata;
    logic        kb_ready;
    logic        overflow;
    logic        seg_clk;
    logic        seg_clrn;
    logic        seg_dt;
    logic        seg_en;

    integer      seed = 32'hb7ad;
    int          checks = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    longint      watch_ns = 0;
    // lit segments per hex digit, one means on, dp dark
    logic [7:0]  font_lit [16];
    // bytes the receiver should be holding
    logic [7:0]  model_q [$];
    logic        model_ovf = 1'b0;

    io_top u_dut (.*);

    always #4 clk200m = ~clk200m;

    // inputs change 1 ns after a rising edge
    task automatic after_edges(input int n);
        repeat (n) @(posedge clk200m);
        #1;
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            value_errs++;
            $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic check_cond(input bit ok, input string what);
        checks++;
        assert (ok) else begin
            other_errs++;
            $display("ERROR: %s", what);
        end
    endtask

    // start, data lsb first, parity, stop; data moves only while ps2_clk is high
    task automatic send_frame(input logic [7:0] b, input bit good);
        logic [10:0] bits;
        bits = {1'b1, good ? ~^b : ^b, b, 1'b0};
        for (int i = 0; i < 11; i++) begin
            ps2_data = bits[i];
            after_edges(half_ps2);
            ps2_clk = 1'b0;
            after_edges(half_ps2);
            ps2_clk = 1'b1;
        end
        after_edges(half_ps2);
        ps2_data = 1'b1;
        // random idle gap, 2 to 17 cycles
        after_edges(2 + ($random(seed) & 15));
    endtask

    task automatic pop_byte(input logic [7:0] exp);
        check_value("ready before read", 1, kb_ready);
        check_value("read byte", exp, kb_rdata);
        rdn = 1'b0;
        after_edges(1);
        rdn = 1'b1;
        if (model_q.size() != 0) begin
            void'(model_q.pop_front());
        end
        // any pop clears overflow
        model_ovf = 1'b0;
        check_value("ready after read", model_q.size() != 0, kb_ready);
        check_value("overflow after read", model_ovf, overflow);
    endtask

    // digit 7 first, each pattern msb first, active low
    function automatic logic [63:0] expected_stream(input logic [31:0] w);
        logic [63:0] s;
        s = '0;
        for (int d = 7; d >= 0; d--) begin
            s = {s[55:0], ~font_lit[w[4*d +: 4]]};
        end
        return s;
    endfunction

    // waits for the next en rise, then takes seg_dt at every rising seg_clk
    task automatic capture_frame(output logic [63:0] stream, output int en_drops, output bit ok);
        int   waited;
        int   got;
        logic prev_en;
        logic prev_clk;
        waited = 0;
        got = 0;
        en_drops = 0;
        stream = '0;
        ok = 1'b0;
        @(negedge clk200m);
        prev_en = seg_en;
        while (!ok && waited < 3 * disp_cycles) begin
            @(negedge clk200m);
            waited++;
            ok = seg_en & ~prev_en;
            prev_en = seg_en;
        end
        prev_clk = seg_clk;
        while (ok && got < 64 && waited < 3 * disp_cycles) begin
            @(negedge clk200m);
            waited++;
            if (!seg_en) begin
                en_drops++;
            end
            if (seg_clk && !prev_clk) begin
                stream = {stream[62:0], seg_dt};
                got++;
            end
            prev_clk = seg_clk;
        end
        ok = (got == 64);
        after_edges(1);
    endtask

    initial begin
        int          fd;
        int          code;
        int          cnt;
        int          n_frames;
        int          n_disp;
        int          en_drops;
        bit          ok;
        string       tok;
        string       line;
        logic [31:0] v;
        logic [63:0] stream;
        string       kinds [$];
        logic [31:0] vals [$];
        int          cnts [$];
        font_lit = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                     8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        rdn = 1'b1;
        num = '0;
        n_frames = 0;
        n_disp = 0;
        fd = $fopen("testbench/io_stimulus.txt", "r");
        check_cond(fd != 0, "cannot open testbench/io_stimulus.txt");
        if (fd != 0) begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    code = $fgets(line, fd);
                end else begin
                    code = $fscanf(fd, "%h %d", v, cnt);
                    check_cond(code == 2, {"malformed stimulus record ", tok});
                    kinds.push_back(tok);
                    vals.push_back(v);
                    cnts.push_back(cnt);
                    n_frames += (tok == "frame" || tok == "badframe") ? cnt : 0;
                    n_disp += (tok == "disp") ? 1 : 0;
                end
            end
            $fclose(fd);
        end
        // ps2 frames, then up to two display frames per word, three spare frames and slack
        watch_ns = n_frames * (12 * 2 * half_ps2 + 20) * 8
                 + (2 * n_disp + 3) * disp_cycles * 8 + 20000;
        after_edges(3);
        rst = 1'b0;
        after_edges(1);
        // kb_ready, overflow, seg_clk, seg_dt, seg_en, seg_clrn
        check_value("outputs after reset", 6'b000001,
                    {kb_ready, overflow, seg_clk, seg_dt, seg_en, seg_clrn});
        foreach (kinds[i]) begin
            case (kinds[i])
                "frame", "badframe": begin
                    for (int k = 0; k < cnts[i]; k++) begin
                        send_frame(vals[i][7:0] + k, kinds[i] == "frame");
                        if (kinds[i] == "frame" && model_q.size() < 8) begin
                            model_q.push_back(vals[i][7:0] + k);
                        end else if (kinds[i] == "frame") begin
                            model_ovf = 1'b1;
                        end
                        check_value("ready after frame", model_q.size() != 0, kb_ready);
                    end
                end
                "read": begin
                    for (int k = 0; k < cnts[i]; k++) begin
                        pop_byte(vals[i][7:0] + k);
                    end
                end
                "ovf": begin
                    check_value("overflow level", vals[i][0], overflow);
                    check_value("overflow model", vals[i][0], model_ovf);
                end
                "disp": begin
                    num = vals[i];
                    capture_frame(stream, en_drops, ok);
                    check_cond(ok, "display frame did not start or finish in time");
                    check_value("display stream", expected_stream(vals[i]), stream);
                    check_value("seg_en low inside frame", 0, en_drops);
                end
                default: check_cond(1'b0, {"unknown stimulus record ", kinds[i]});
            endcase
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // run length limit, armed once the stimulus is counted
    initial begin
        wait (watch_ns != 0);
        #(watch_ns);
        $display("watchdog expired after %0d ns, the run stalled", watch_ns);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: testbench/io_stimulus.txt
# kind value(hex) count(dec): frame/badframe send count bytes from value up, read expects
# count bytes from value up, disp sets the display word, ovf expects the overflow level
disp 0123abcd 1
frame 1c 1
frame 32 1
frame 5a 1
read 1c 1
read 32 1
read 5a 1
badframe 21 1
frame 44 1
read 44 1
frame 01 9
ovf 1 1
read 01 1
ovf 0 1
read 02 7
disp 89efcd45 1

// File: flist.f
+incdir+verilog
verilog/soc_io_pkg.sv
verilog/seg_hex_encoder.sv
verilog/ps2_kbd.sv
verilog/seg_shifter.sv
verilog/io_top.sv
testbench/tb_io_top.sv

// File: Bender.yml
package:
  name: soc_io

export_include_dirs:
  - verilog

sources:
  - verilog/soc_io_pkg.sv
  - verilog/seg_hex_encoder.sv
  - verilog/ps2_kbd.sv
  - verilog/seg_shifter.sv
  - verilog/io_top.sv
  - target: test
    files:
      - testbench/tb_io_top.sv
